// File: rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int WORD_SIZE = 16;

    // four architectural registers, addressed by two-bit fields
    localparam int REG_BITS = 2;
    localparam int NUM_REGS = 4;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_e;

    // only meaningful when the opcode is OP_RTYPE
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_e;

endpackage

// File: rtl/control_unit.sv
module control_unit import cpu_pkg::*; (
    input  logic [WORD_SIZE-1:0] instr,
    output logic                 reg_dst,
    output logic                 reg_write,
    output logic                 mem_to_reg,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 alu_src,
    output logic                 is_branch,
    output logic                 is_jump,
    output logic                 is_lhi,
    output logic                 is_wwd,
    output logic                 is_hlt,
    output logic                 use_rs,
    output logic                 use_rt
);

    opcode_e opcode;
    func_e   func;
    logic    known;

    assign opcode = opcode_e'(instr[15:12]);
    assign func   = func_e'(instr[5:0]);

    always_comb begin
        reg_dst    = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        alu_src    = 1'b0;
        is_branch  = 1'b0;
        is_jump    = 1'b0;
        is_lhi     = 1'b0;
        is_wwd     = 1'b0;
        is_hlt     = 1'b0;
        use_rs     = 1'b0;
        use_rt     = 1'b0;
        known      = 1'b1;
        case (opcode)
            OP_RTYPE: begin
                case (func)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
                        reg_dst   = 1'b1;
                        reg_write = 1'b1;
                        use_rs    = 1'b1;
                        use_rt    = 1'b1;
                    end
                    FN_WWD: begin
                        is_wwd = 1'b1;
                        use_rs = 1'b1;
                    end
                    FN_HLT: is_hlt = 1'b1;
                    default: known = 1'b0;
                endcase
            end
            OP_ADI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                use_rs    = 1'b1;
            end
            OP_LHI: begin
                reg_write = 1'b1;
                is_lhi    = 1'b1;
            end
            OP_LWD: begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                mem_read   = 1'b1;
                alu_src    = 1'b1;
                use_rs     = 1'b1;
            end
            OP_SWD: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                use_rs    = 1'b1;
                use_rt    = 1'b1;
            end
            OP_BNE, OP_BEQ: begin
                is_branch = 1'b1;
                use_rs    = 1'b1;
                use_rt    = 1'b1;
            end
            OP_JMP: is_jump = 1'b1;
            default: known = 1'b0;
        endcase
    end

    // an undefined word flows down the pipe like a bubble
    always_comb begin
        if (!known) begin
            assert (!(reg_write || mem_write || mem_read || is_branch || is_jump
                      || is_wwd || is_hlt))
                else $error("undefined instruction %h decodes with side effects", instr);
        end
    end

endmodule

// File: rtl/register_file.sv
module register_file import cpu_pkg::*; (
    input  logic                 Clk,
    input  logic                 arst_n,
    input  logic [REG_BITS-1:0]  rs,
    input  logic [REG_BITS-1:0]  rt,
    input  logic [REG_BITS-1:0]  wr_addr,
    input  logic [WORD_SIZE-1:0] wr_data,
    input  logic                 wr_en,
    output logic [WORD_SIZE-1:0] rs_data,
    output logic [WORD_SIZE-1:0] rt_data
);

    logic [WORD_SIZE-1:0] regs [NUM_REGS];

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through, decode sees the value retiring this cycle
    assign rs_data = (wr_en && wr_addr == rs) ? wr_data : regs[rs];
    assign rt_data = (wr_en && wr_addr == rt) ? wr_data : regs[rt];

endmodule

// File: rtl/alu.sv
module alu import cpu_pkg::*; (
    input  opcode_e              opcode,
    input  func_e                func,
    input  logic [WORD_SIZE-1:0] a,
    input  logic [WORD_SIZE-1:0] b,
    output logic [WORD_SIZE-1:0] result,
    output logic                 bcond
);

    alu_op_e op;

    // address arithmetic for ADI, LWD and SWD falls to the add default
    always_comb begin
        case (opcode)
            OP_BNE, OP_BEQ: op = ALU_SUB;
            OP_RTYPE: begin
                case (func)
                    FN_SUB:  op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_ORR:  op = ALU_OR;
                    default: op = ALU_ADD;
                endcase
            end
            default: op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (op)
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            default: result = a + b;
        endcase
    end

    // branches compare through the subtractor
    always_comb begin
        case (opcode)
            OP_BNE:  bcond = (result != '0);
            OP_BEQ:  bcond = (result == '0);
            default: bcond = 1'b0;
        endcase
    end

endmodule

// File: rtl/hazard_forward.sv
module hazard_forward import cpu_pkg::*; (
    input  logic [REG_BITS-1:0] ex_rs,
    input  logic [REG_BITS-1:0] ex_rt,
    input  logic [REG_BITS-1:0] mem_rd,
    input  logic                mem_reg_write,
    input  logic [REG_BITS-1:0] wb_rd,
    input  logic                wb_reg_write,
    input  logic [REG_BITS-1:0] id_rs,
    input  logic [REG_BITS-1:0] id_rt,
    input  logic                id_use_rs,
    input  logic                id_use_rt,
    input  logic                ex_mem_read,
    input  logic [REG_BITS-1:0] ex_rd,
    output logic [1:0]          fwd_a,
    output logic [1:0]          fwd_b,
    output logic                stall
);

    // 01 takes EX/MEM, 10 takes MEM/WB, the younger result wins
    assign fwd_a = (mem_reg_write && mem_rd == ex_rs) ? 2'b01 :
                   (wb_reg_write && wb_rd == ex_rs)   ? 2'b10 : 2'b00;
    assign fwd_b = (mem_reg_write && mem_rd == ex_rt) ? 2'b01 :
                   (wb_reg_write && wb_rd == ex_rt)   ? 2'b10 : 2'b00;

    // load data only exists after MEM, so the consumer waits one cycle
    assign stall = ex_mem_read && ((id_use_rs && id_rs == ex_rd) ||
                                   (id_use_rt && id_rt == ex_rd));

endmodule

// File: rtl/datapath.sv
module datapath import cpu_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  logic                 Clk,
    input  logic                 arst_n,
    input  logic                 start,
    output logic [ADDR_BITS-1:0] imem_addr,
    input  logic [WORD_SIZE-1:0] imem_data,
    output logic [WORD_SIZE-1:0] dmem_addr,
    output logic [WORD_SIZE-1:0] dmem_wdata,
    output logic                 dmem_we,
    output logic                 dmem_re,
    input  logic [WORD_SIZE-1:0] dmem_rdata,
    output logic                 wwd_valid,
    output logic [WORD_SIZE-1:0] wwd_data,
    output logic                 halted,
    output logic [WORD_SIZE-1:0] num_inst
);

    logic [ADDR_BITS-1:0] pc, next_pc, id_pc, ex_pc;
    logic                 running;

    logic                 id_valid;
    logic [WORD_SIZE-1:0] id_instr, id_rs_data, id_rt_data;
    logic [REG_BITS-1:0]  id_rs, id_rt, id_rd;
    logic reg_dst, reg_write, mem_to_reg, mem_read, mem_write, alu_src;
    logic is_branch, is_jump, is_lhi, is_wwd, is_hlt, use_rs, use_rt;
    logic stall, jump_taken;

    logic                 ex_valid;
    opcode_e              ex_opcode;
    func_e                ex_func;
    logic [REG_BITS-1:0]  ex_rs, ex_rt, ex_rd;
    logic [WORD_SIZE-1:0] ex_rs_data, ex_rt_data, ex_imm;
    logic ex_reg_write, ex_mem_to_reg, ex_mem_read, ex_mem_write, ex_alu_src;
    logic ex_is_branch, ex_is_lhi, ex_is_wwd, ex_is_hlt;
    logic [1:0]           fwd_a, fwd_b;
    logic [WORD_SIZE-1:0] op_a, op_b, alu_b, alu_result, ex_result;
    logic                 bcond, branch_taken;

    logic                 mem_valid, mem_reg_write, mem_mem_to_reg;
    logic                 mem_mem_read, mem_mem_write, mem_is_wwd, mem_is_hlt;
    logic [REG_BITS-1:0]  mem_rd;
    logic [WORD_SIZE-1:0] mem_result, mem_store;

    logic                 wb_valid, wb_reg_write, wb_mem_to_reg, wb_is_wwd, wb_is_hlt;
    logic                 halt_now;
    logic [REG_BITS-1:0]  wb_rd;
    logic [WORD_SIZE-1:0] wb_result, wb_load, wb_data;

    assign imem_addr = pc;

    assign id_rs      = id_instr[11:10];
    assign id_rt      = id_instr[9:8];
    assign id_rd      = reg_dst ? id_instr[7:6] : id_instr[9:8];
    // an older taken branch kills the jump sitting in decode
    assign jump_taken = id_valid && is_jump && !branch_taken;

    control_unit i_control_unit (
        .instr(id_instr), .reg_dst(reg_dst), .reg_write(reg_write),
        .mem_to_reg(mem_to_reg), .mem_read(mem_read), .mem_write(mem_write),
        .alu_src(alu_src), .is_branch(is_branch), .is_jump(is_jump), .is_lhi(is_lhi),
        .is_wwd(is_wwd), .is_hlt(is_hlt), .use_rs(use_rs), .use_rt(use_rt)
    );

    register_file i_register_file (
        .Clk(Clk), .arst_n(arst_n), .rs(id_rs), .rt(id_rt), .wr_addr(wb_rd),
        .wr_data(wb_data), .wr_en(wb_valid && wb_reg_write),
        .rs_data(id_rs_data), .rt_data(id_rt_data)
    );

    hazard_forward i_hazard_forward (
        .ex_rs(ex_rs), .ex_rt(ex_rt),
        .mem_rd(mem_rd), .mem_reg_write(mem_valid && mem_reg_write),
        .wb_rd(wb_rd), .wb_reg_write(wb_valid && wb_reg_write),
        .id_rs(id_rs), .id_rt(id_rt),
        .id_use_rs(id_valid && use_rs), .id_use_rt(id_valid && use_rt),
        .ex_mem_read(ex_valid && ex_mem_read), .ex_rd(ex_rd),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
    );

    assign op_a  = (fwd_a == 2'b01) ? mem_result : (fwd_a == 2'b10) ? wb_data : ex_rs_data;
    assign op_b  = (fwd_b == 2'b01) ? mem_result : (fwd_b == 2'b10) ? wb_data : ex_rt_data;
    assign alu_b = ex_alu_src ? ex_imm : op_b;

    alu i_alu (
        .opcode(ex_opcode), .func(ex_func), .a(op_a), .b(alu_b),
        .result(alu_result), .bcond(bcond)
    );

    assign branch_taken = ex_valid && ex_is_branch && bcond;
    // LHI skips the ALU, WWD carries rs down to writeback
    assign ex_result = ex_is_lhi ? {ex_imm[7:0], 8'h00} : ex_is_wwd ? op_a : alu_result;

    always_comb begin
        if (stall) begin
            next_pc = pc;
        end else if (branch_taken) begin
            next_pc = ex_pc + ADDR_BITS'(1) + ADDR_BITS'(ex_imm);
        end else if (jump_taken) begin
            next_pc = ADDR_BITS'(id_instr[11:0]);
        end else begin
            next_pc = pc + ADDR_BITS'(1);
        end
    end

    assign halt_now   = wb_valid && wb_is_hlt;
    assign dmem_addr  = mem_result;
    assign dmem_wdata = mem_store;
    // a store younger than the retiring HLT must not land
    assign dmem_we    = mem_valid && mem_mem_write && !halt_now;
    assign dmem_re    = mem_valid && mem_mem_read;
    assign wb_data    = wb_mem_to_reg ? wb_load : wb_result;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= '0;
            running   <= 1'b0;
            halted    <= 1'b0;
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
            wwd_valid <= 1'b0;
            num_inst  <= '0;
        end else begin
            wwd_valid <= wb_valid && wb_is_wwd;
            if (wb_valid) begin
                num_inst <= num_inst + WORD_SIZE'(1);
            end
            if (halt_now) begin
                halted    <= 1'b1;
                running   <= 1'b0;
                id_valid  <= 1'b0;
                ex_valid  <= 1'b0;
                mem_valid <= 1'b0;
                wb_valid  <= 1'b0;
            end else begin
                if (start && !running && !halted) begin
                    running <= 1'b1;
                    pc      <= '0;
                end else if (running) begin
                    pc <= next_pc;
                end
                if (!stall) begin
                    id_valid <= running && !branch_taken && !jump_taken;
                end
                ex_valid  <= id_valid && !stall && !branch_taken;
                mem_valid <= ex_valid;
                wb_valid  <= mem_valid;
            end
        end
    end

    // stage contents, only meaningful while the valid bit is set
    always_ff @(posedge Clk) begin
        if (!stall) begin
            id_instr <= imem_data;
            id_pc    <= pc;
        end
        ex_opcode     <= opcode_e'(id_instr[15:12]);
        ex_func       <= func_e'(id_instr[5:0]);
        ex_pc         <= id_pc;
        ex_rs         <= id_rs;
        ex_rt         <= id_rt;
        ex_rd         <= id_rd;
        ex_rs_data    <= id_rs_data;
        ex_rt_data    <= id_rt_data;
        ex_imm        <= {{8{id_instr[7]}}, id_instr[7:0]};
        ex_reg_write  <= reg_write;
        ex_mem_to_reg <= mem_to_reg;
        ex_mem_read   <= mem_read;
        ex_mem_write  <= mem_write;
        ex_alu_src    <= alu_src;
        ex_is_branch  <= is_branch;
        ex_is_lhi     <= is_lhi;
        ex_is_wwd     <= is_wwd;
        ex_is_hlt     <= is_hlt;

        mem_result     <= ex_result;
        mem_store      <= op_b;
        mem_rd         <= ex_rd;
        mem_reg_write  <= ex_reg_write;
        mem_mem_to_reg <= ex_mem_to_reg;
        mem_mem_read   <= ex_mem_read;
        mem_mem_write  <= ex_mem_write;
        mem_is_wwd     <= ex_is_wwd;
        mem_is_hlt     <= ex_is_hlt;

        wb_result     <= mem_result;
        wb_load       <= dmem_rdata;
        wb_rd         <= mem_rd;
        wb_reg_write  <= mem_reg_write;
        wb_mem_to_reg <= mem_mem_to_reg;
        wb_is_wwd     <= mem_is_wwd;
        wb_is_hlt     <= mem_is_hlt;

        wwd_data <= wb_result;
    end

    // the stall bubble carries no load, so it cannot stall again
    assert property (@(posedge Clk) disable iff (!arst_n) stall |=> !stall);

    // nothing retires once the HLT has drained the pipe
    assert property (@(posedge Clk) disable iff (!arst_n) halted |-> !wwd_valid);

    // every memory write traces back to a live instruction in execute
    assert property (@(posedge Clk) disable iff (!arst_n) dmem_we |-> $past(ex_valid));

endmodule

// File: rtl/cpu_memory.sv
module cpu_memory #(
    parameter int ADDR_BITS = 8
) (
    input  logic                 Clk,
    input  logic                 prog_we,
    input  logic [15:0]          prog_addr,
    input  logic [15:0]          prog_data,
    input  logic [ADDR_BITS-1:0] imem_addr,
    output logic [15:0]          imem_data,
    input  logic [15:0]          dmem_addr,
    input  logic [15:0]          dmem_wdata,
    input  logic                 dmem_we,
    output logic [15:0]          dmem_rdata
);

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [15:0] imem [DEPTH];
    logic [15:0] dmem [DEPTH];

    // upper address bits are dropped, so accesses wrap
    always_ff @(posedge Clk) begin
        if (prog_we) begin
            imem[prog_addr[ADDR_BITS-1:0]] <= prog_data;
        end
        if (dmem_we) begin
            dmem[dmem_addr[ADDR_BITS-1:0]] <= dmem_wdata;
        end
    end

    assign imem_data  = imem[imem_addr];
    assign dmem_rdata = dmem[dmem_addr[ADDR_BITS-1:0]];

endmodule

// File: rtl/cpu_top.sv
module cpu_top import cpu_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  logic                 Clk,
    input  logic                 arst_n,
    input  logic                 prog_we,
    input  logic [WORD_SIZE-1:0] prog_addr,
    input  logic [WORD_SIZE-1:0] prog_data,
    input  logic                 start,
    output logic                 wwd_valid,
    output logic [WORD_SIZE-1:0] wwd_data,
    output logic                 halted,
    output logic [WORD_SIZE-1:0] num_inst
);

    logic [ADDR_BITS-1:0] imem_addr;
    logic [WORD_SIZE-1:0] imem_data, dmem_addr, dmem_wdata, dmem_rdata;
    logic                 dmem_we;

    // memory reads are combinational and need no read strobe
    datapath #(.ADDR_BITS(ADDR_BITS)) i_datapath (
        .Clk(Clk), .arst_n(arst_n), .start(start),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_re(), .dmem_rdata(dmem_rdata),
        .wwd_valid(wwd_valid), .wwd_data(wwd_data),
        .halted(halted), .num_inst(num_inst)
    );

    cpu_memory #(.ADDR_BITS(ADDR_BITS)) i_cpu_memory (
        .Clk(Clk), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata)
    );

endmodule

// File: testbench/cpu_checker.sv
module cpu_checker (
    input  logic        Clk,
    input  logic        arst_n,
    input  logic        wwd_valid,
    input  logic [15:0] wwd_data,
    input  logic        halted,
    input  logic [15:0] num_inst,
    input  logic [63:0] test_name,
    input  logic [15:0] exp_wwd [4],
    input  int          exp_wwd_cnt,
    input  logic [15:0] exp_num_inst,
    input  logic        check,
    input  logic        abort,
    output int          pass_count,
    output int          fail_count
);

    logic [15:0] seen [8];
    int          seen_cnt;
    logic        halt_seen;
    logic        halt_dropped;
    logic        wwd_while_halted;

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    // strobes of the current run, cleared by the DUT reset
    always @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            seen_cnt         <= 0;
            halt_seen        <= 1'b0;
            halt_dropped     <= 1'b0;
            wwd_while_halted <= 1'b0;
        end else begin
            if (wwd_valid) begin
                if (seen_cnt < 8) begin
                    seen[seen_cnt[2:0]] <= wwd_data;
                end
                seen_cnt <= seen_cnt + 1;
                if (halted) begin
                    wwd_while_halted <= 1'b1;
                end
            end
            if (halted) begin
                halt_seen <= 1'b1;
            end else if (halt_seen) begin
                halt_dropped <= 1'b1;
            end
        end
    end

    task automatic compare_run();
        int errors;
        int n;
        errors = 0;
        n = (seen_cnt < exp_wwd_cnt) ? seen_cnt : exp_wwd_cnt;
        for (int i = 0; i < n; i++) begin
            if (seen[i[2:0]] !== exp_wwd[i[1:0]]) begin
                $display("FAIL %0s wwd %0d expected %h actual %h",
                         test_name, i, exp_wwd[i[1:0]], seen[i[2:0]]);
                errors++;
            end
        end
        if (seen_cnt != exp_wwd_cnt) begin
            $display("test %0s: expected %0d WWD outputs but saw %0d",
                     test_name, exp_wwd_cnt, seen_cnt);
            errors++;
        end
        if (num_inst !== exp_num_inst) begin
            $display("FAIL %0s num_inst expected %0d actual %0d",
                     test_name, exp_num_inst, num_inst);
            errors++;
        end
        if (wwd_while_halted) begin
            $display("test %0s: a WWD strobe appeared while the core was halted", test_name);
            errors++;
        end
        if (halt_dropped || !halted) begin
            $display("test %0s: halted went low again before reset", test_name);
            errors++;
        end
        if (errors == 0) begin
            pass_count++;
            $display("test %0s: passed", test_name);
        end else begin
            fail_count++;
            $display("test %0s: failed", test_name);
        end
    endtask

    always @(posedge Clk) begin
        if (check) begin
            compare_run();
        end else if (abort) begin
            fail_count++;
            $display("test %0s: failed", test_name);
        end
    end

endmodule

// File: testbench/tb_cpu.sv
module tb_cpu;

    localparam int NUM_TESTS    = 5;
    localparam int MAX_WORDS    = 16;
    localparam int HALT_TIMEOUT = 500;
    localparam int HOLD_CYCLES  = 20;
    localparam logic [15:0] HLT_WORD = 16'hF01D;

    logic        Clk;
    logic        arst_n;
    logic        prog_we;
    logic [15:0] prog_addr;
    logic [15:0] prog_data;
    logic        start;
    logic        wwd_valid;
    logic [15:0] wwd_data;
    logic        halted;
    logic [15:0] num_inst;

    logic [63:0] test_name;
    logic [15:0] exp_wwd [4];
    int          exp_wwd_cnt;
    logic [15:0] exp_num_inst;
    logic        check;
    logic        abort;
    int          pass_count;
    int          fail_count;

    // one row per test: name, program, expected WWD values and retired count
    logic [63:0] names [NUM_TESTS];
    logic [15:0] prog [NUM_TESTS][MAX_WORDS];
    int          prog_len [NUM_TESTS];
    logic [15:0] wwd_table [NUM_TESTS][4];
    int          wwd_cnt_table [NUM_TESTS];
    logic [15:0] num_table [NUM_TESTS];

    cpu_top #(.ADDR_BITS(8)) i_cpu_top (
        .Clk(Clk), .arst_n(arst_n), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .start(start), .wwd_valid(wwd_valid),
        .wwd_data(wwd_data), .halted(halted), .num_inst(num_inst)
    );

    cpu_checker i_cpu_checker (
        .Clk(Clk), .arst_n(arst_n), .wwd_valid(wwd_valid), .wwd_data(wwd_data),
        .halted(halted), .num_inst(num_inst), .test_name(test_name),
        .exp_wwd(exp_wwd), .exp_wwd_cnt(exp_wwd_cnt), .exp_num_inst(exp_num_inst),
        .check(check), .abort(abort), .pass_count(pass_count), .fail_count(fail_count)
    );

    always #5 Clk = ~Clk;

    task automatic set_row(input int t, input logic [63:0] name, input int len,
                           input int wwd_cnt, input logic [15:0] num);
        names[t]         = name;
        prog_len[t]      = len;
        wwd_cnt_table[t] = wwd_cnt;
        num_table[t]     = num;
    endtask

    task automatic fill_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int k = 0; k < 4; k++) begin
                wwd_table[t][k] = '0;
            end
        end
        // back-to-back dependencies through both forwarding paths
        set_row(0, "alu_fwds", 12, 4, 16'd12);
        prog[0][0]  = 16'h6112;  // lhi r1, 0x12
        prog[0][1]  = 16'h4534;  // adi r1, r1, 0x34
        prog[0][2]  = 16'h4256;  // adi r2, r0, 0x56
        prog[0][3]  = 16'hF6C0;  // add r3, r1, r2
        prog[0][4]  = 16'hFC1C;  // wwd r3
        prog[0][5]  = 16'hF6C1;  // sub r3, r1, r2
        prog[0][6]  = 16'hFC1C;
        prog[0][7]  = 16'hF6C2;  // and r3, r1, r2
        prog[0][8]  = 16'hFC1C;
        prog[0][9]  = 16'hF6C3;  // orr r3, r1, r2
        prog[0][10] = 16'hFC1C;
        prog[0][11] = HLT_WORD;
        wwd_table[0][0] = 16'h128A;
        wwd_table[0][1] = 16'h11DE;
        wwd_table[0][2] = 16'h0014;
        wwd_table[0][3] = 16'h1276;
        set_row(1, "load_use", 8, 1, 16'd8);
        prog[1][0] = 16'h4110;  // adi r1, r0, 0x10
        prog[1][1] = 16'h625A;  // lhi r2, 0x5a
        prog[1][2] = 16'h4A3C;  // adi r2, r2, 0x3c
        prog[1][3] = 16'h8602;  // swd r2, 2(r1)
        prog[1][4] = 16'h7702;  // lwd r3, 2(r1)
        prog[1][5] = 16'hFD00;  // add r0, r3, r1 stalls one cycle
        prog[1][6] = 16'hF01C;  // wwd r0
        prog[1][7] = HLT_WORD;
        wwd_table[1][0] = 16'h5A4C;
        set_row(2, "branches", 9, 1, 16'd7);
        prog[2][0] = 16'h4105;  // adi r1, r0, 5
        prog[2][1] = 16'h4205;  // adi r2, r0, 5
        prog[2][2] = 16'h1602;  // beq r1, r2, +2 taken
        prog[2][3] = 16'hF41C;  // skipped
        prog[2][4] = 16'hF81C;  // skipped
        prog[2][5] = 16'h4307;  // adi r3, r0, 7
        prog[2][6] = 16'h0601;  // bne r1, r2, +1 not taken
        prog[2][7] = 16'hFC1C;  // wwd r3
        prog[2][8] = HLT_WORD;
        wwd_table[2][0] = 16'h0007;
        set_row(3, "jmp_over", 8, 2, 16'd6);
        prog[3][0] = 16'h4111;  // adi r1, r0, 0x11
        prog[3][1] = 16'h9004;  // jmp 4
        prog[3][2] = 16'hF41C;  // flushed in fetch
        prog[3][3] = 16'h4501;  // never fetched
        prog[3][4] = 16'hF41C;  // wwd r1
        prog[3][5] = 16'h4622;  // adi r2, r1, 0x22
        prog[3][6] = 16'hF81C;  // wwd r2
        prog[3][7] = HLT_WORD;
        wwd_table[3][0] = 16'h0011;
        wwd_table[3][1] = 16'h0033;
        // WWD words sit behind the HLT and must stay silent
        set_row(4, "halt_end", 6, 1, 16'd3);
        prog[4][0] = 16'h617E;  // lhi r1, 0x7e
        prog[4][1] = 16'hF41C;  // wwd r1
        prog[4][2] = HLT_WORD;
        prog[4][3] = 16'hF41C;
        prog[4][4] = 16'hF01C;
        prog[4][5] = 16'hF41C;
        wwd_table[4][0] = 16'h7E00;
    endtask

    task automatic apply_reset();
        @(negedge Clk);
        arst_n = 1'b0;
        repeat (2) @(negedge Clk);
        arst_n = 1'b1;
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < MAX_WORDS; i++) begin
            @(negedge Clk);
            prog_we   = 1'b1;
            prog_addr = 16'(i);
            prog_data = (i < prog_len[t]) ? prog[t][i] : HLT_WORD;
        end
        @(negedge Clk);
        prog_we = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge Clk);
        start = 1'b1;
        @(negedge Clk);
        start = 1'b0;
    endtask

    task automatic signal_checker(input logic timed_out);
        @(negedge Clk);
        check = !timed_out;
        abort = timed_out;
        @(negedge Clk);
        check = 1'b0;
        abort = 1'b0;
    endtask

    task automatic run_test(input int t);
        int cycles;
        test_name    = names[t];
        exp_wwd_cnt  = wwd_cnt_table[t];
        exp_num_inst = num_table[t];
        for (int k = 0; k < 4; k++) begin
            exp_wwd[k] = wwd_table[t][k];
        end
        apply_reset();
        load_program(t);
        pulse_start();
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge Clk);
            cycles++;
        end
        if (halted) begin
            // a second start must not wake a halted core
            pulse_start();
            repeat (HOLD_CYCLES) @(negedge Clk);
            signal_checker(1'b0);
        end else begin
            $display("test %0s: timed out, halted not seen within %0d cycles",
                     names[t], HALT_TIMEOUT);
            signal_checker(1'b1);
        end
    endtask

    initial begin
        Clk          = 1'b0;
        arst_n       = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        start        = 1'b0;
        check        = 1'b0;
        abort        = 1'b0;
        test_name    = '0;
        exp_wwd_cnt  = 0;
        exp_num_inst = '0;
        for (int k = 0; k < 4; k++) begin
            exp_wwd[k] = '0;
        end
        fill_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        @(negedge Clk);
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == NUM_TESTS) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/cpu_pkg.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/hazard_forward.sv
rtl/datapath.sv
rtl/cpu_memory.sv
rtl/cpu_top.sv
testbench/cpu_checker.sv
testbench/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_cpu
./obj_dir/Vtb_cpu | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
